//--- logic/bp_pkg.sv
/*
 * Shared definitions for the fetch/decode front end.
 * Widths, the branch opcode, the 2-bit counter states and the
 * instruction word layout used by fetch, predictor and decode.
 */
package bp_pkg;

  localparam int pc_w   = 16;  // PC and target width.
  localparam int flag_w = 3;   // Negative, zero, overflow.
  localparam int op_w   = 4;   // Opcode field width.

  localparam logic [op_w-1:0] branch_op = 4'hb;  // Conditional branch opcode.

  ////////////////////
  // Counter states
  ////////////////////
  // Taken is the MSB of the encoding.
  typedef enum logic [1:0] {
    strong_not_taken = 2'd0,
    weak_not_taken   = 2'd1,
    weak_taken       = 2'd2,
    strong_taken     = 2'd3
  } state_t;

  ////////////////////
  // Instruction word
  ////////////////////
  typedef struct packed {
    logic [op_w-1:0] opcode;   // Major opcode.
    logic [11:0]     payload;  // Opcode specific fields.
  } generic_t;

  typedef struct packed {
    logic [op_w-1:0]        opcode;  // Equals branch_op.
    logic [flag_w-1:0]      cond;    // Flags mask, taken if any masked flag set.
    logic signed [8:0]      offset;  // Word offset from pc + 2.
  } branch_t;

  // One word, two decodes.
  typedef union packed {
    generic_t generic;  // Opcode check.
    branch_t  branch;   // Condition and offset.
  } instr_t;

endpackage

//--- logic/fetch_stage.sv
/*
 * Fetch stage. Holds the PC, picks the next one from redirect,
 * prediction or PC+2, and loads the fetch-to-decode register.
 * A redirect from decode flushes the word fetched in the same cycle.
 */
`timescale 1ns/10ps

module fetch_stage
  import bp_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  instr_t           instr,               // Word at fetch_pc, same cycle.
  input  logic             predicted_taken,     // From the predictor.
  input  state_t           prediction,
  input  logic [pc_w-1:0]  predicted_target,
  input  logic             redirect,            // Mispredict strobe from decode.
  input  logic [pc_w-1:0]  redirect_pc,
  output logic [pc_w-1:0]  fetch_pc,
  output logic             id_valid,
  output logic [pc_w-1:0]  id_pc,
  output instr_t           id_instr,
  output state_t           id_prediction,
  output logic             id_predicted_taken,
  output logic [pc_w-1:0]  id_predicted_target
);

  logic [pc_w-1:0] seq_pc;   // Fall-through address.
  logic [pc_w-1:0] next_pc;  // Address fetched next cycle.

  ////////////////////
  // Next PC
  ////////////////////
  assign seq_pc = fetch_pc + pc_w'(2);  // Halfword step.

  always_comb begin
    if (redirect) begin
      next_pc = redirect_pc;  // Decode correction wins.
    end else if (predicted_taken) begin
      next_pc = predicted_target;  // Follow the BTB.
    end else begin
      next_pc = seq_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_pc <= '0;  // Boot address.
    end else begin
      fetch_pc <= next_pc;
    end
  end

  ////////////////////
  // Decode register
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;
    end else begin
      id_valid <= !redirect;  // Wrong-path word is dropped.
    end
  end

  // Payload follows the valid bit.
  always_ff @(posedge clk) begin
    id_pc               <= fetch_pc;
    id_instr            <= instr;
    id_prediction       <= prediction;        // State fetch relied on.
    id_predicted_taken  <= predicted_taken;
    id_predicted_target <= predicted_target;
  end

  // Redirect and BTB targets are always halfword aligned.
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (rst) !fetch_pc[0]
  );

endmodule

//--- logic/branch_predictor.sv
/*
 * Branch predictor with a tagged BHT of 2-bit counters and a BTB.
 * Answers combinationally for the fetch PC and takes its update
 * from decode one cycle later. Writes need enable.
 */
`timescale 1ns/10ps

module branch_predictor
  import bp_pkg::*;
#(
  parameter int index_bits = 3  // log2 of the table depth.
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             enable,            // Predictor on.
  input  logic [pc_w-1:0]  fetch_pc,          // Read address.
  input  logic [pc_w-1:0]  id_pc,             // Write address, from decode.
  input  state_t           id_prediction,     // State used when id_pc was fetched.
  input  logic             wen_bht,
  input  logic             wen_btb,
  input  logic             actual_taken,
  input  logic [pc_w-1:0]  actual_target,
  output logic             predicted_taken,
  output state_t           prediction,
  output logic [pc_w-1:0]  predicted_target
);

  localparam int entries = 1 << index_bits;
  localparam int tag_w   = pc_w - index_bits;  // Upper PC bits plus bit 0.

  // Tables as packed arrays.
  logic [entries-1:0]             bht_valid;
  logic [entries-1:0][1:0]        bht_state;
  logic [entries-1:0][tag_w-1:0]  bht_tag;
  logic [entries-1:0][tag_w-1:0]  btb_tag;
  logic [entries-1:0][pc_w-1:0]   btb_target;

  logic [index_bits-1:0] rd_idx;
  logic [index_bits-1:0] wr_idx;
  logic [tag_w-1:0]      rd_tag;
  logic [tag_w-1:0]      wr_tag;
  logic                  bht_hit;          // Valid entry for this fetch PC.
  logic                  btb_hit;
  logic                  wr_tag_match;     // Entry still owned by the writer.
  state_t                next_state;

  ////////////////////
  // Index and tag
  ////////////////////
  assign rd_idx = fetch_pc[index_bits:1];                         // Bit 0 skipped.
  assign wr_idx = id_pc[index_bits:1];
  assign rd_tag = {fetch_pc[pc_w-1:index_bits+1], fetch_pc[0]};   // Remaining bits.
  assign wr_tag = {id_pc[pc_w-1:index_bits+1], id_pc[0]};

  ////////////////////
  // Read side
  ////////////////////
  assign bht_hit = enable && bht_valid[rd_idx] && (bht_tag[rd_idx] == rd_tag);
  assign btb_hit = enable && (btb_tag[rd_idx] == rd_tag);  // No read while off.

  assign prediction       = bht_hit ? state_t'(bht_state[rd_idx]) : weak_not_taken;
  assign predicted_taken  = prediction[1];                       // MSB means taken.
  assign predicted_target = btb_hit ? btb_target[rd_idx] : '0;

  ////////////////////
  // Counter update
  ////////////////////
  assign wr_tag_match = (bht_tag[wr_idx] == wr_tag);

  always_comb begin
    case (id_prediction)
      strong_not_taken: begin
        if (wr_tag_match) begin
          next_state = actual_taken ? weak_not_taken : strong_not_taken;
        end else begin
          next_state = weak_not_taken;  // Entry was taken over, restart.
        end
      end
      weak_not_taken: begin
        next_state = actual_taken ? weak_taken : strong_not_taken;  // Miss state lands here.
      end
      weak_taken: begin
        if (wr_tag_match) begin
          next_state = actual_taken ? strong_taken : weak_not_taken;
        end else begin
          next_state = weak_not_taken;
        end
      end
      strong_taken: begin
        if (wr_tag_match) begin
          next_state = actual_taken ? strong_taken : weak_taken;  // Saturates.
        end else begin
          next_state = weak_not_taken;
        end
      end
      default: begin
        next_state = weak_not_taken;
      end
    endcase
  end

  ////////////////////
  // Table writes
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      bht_valid  <= '0;                              // All entries miss.
      bht_state  <= {entries{strong_not_taken}};
      bht_tag    <= '0;
      btb_tag    <= '0;
      btb_target <= '0;
    end else begin
      if (enable && wen_bht) begin
        bht_valid[wr_idx] <= 1'b1;
        bht_tag[wr_idx]   <= wr_tag;
        bht_state[wr_idx] <= next_state;
      end
      if (enable && wen_btb) begin
        btb_tag[wr_idx]    <= wr_tag;
        btb_target[wr_idx] <= actual_target;  // Resolved target only.
      end
    end
  end

  ////////////////////
  // Checks
  ////////////////////
  // The carried state has to survive the trip through fetch and decode.
  a_known_state : assert property (
    @(posedge clk) disable iff (rst) wen_bht |-> !$isunknown(id_prediction)
  );

  // Disabled predictor leaves every table untouched.
  a_frozen_off : assert property (
    @(posedge clk) disable iff (rst)
      !enable |=> ($stable(bht_valid) && $stable(bht_state) && $stable(bht_tag)
                   && $stable(btb_tag) && $stable(btb_target))
  );

  // Decode only fills the BTB for taken branches.
  a_btb_taken : assert property (
    @(posedge clk) disable iff (rst) wen_btb |-> actual_taken
  );

endmodule

//--- logic/branch_resolver.sv
/*
 * Decode stage. Resolves branches against the flags, checks the
 * prediction carried from fetch, redirects fetch on a mispredict,
 * drives predictor updates and registers the retire report.
 */
`timescale 1ns/10ps

module branch_resolver
  import bp_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               id_valid,
  input  logic [pc_w-1:0]    id_pc,
  input  instr_t             id_instr,
  input  state_t             id_prediction,
  input  logic               id_predicted_taken,
  input  logic [pc_w-1:0]    id_predicted_target,
  input  logic [flag_w-1:0]  flags,               // N, Z, V levels.
  output logic               wen_bht,
  output logic               wen_btb,
  output logic               actual_taken,
  output logic [pc_w-1:0]    actual_target,
  output logic               redirect,
  output logic [pc_w-1:0]    redirect_pc,
  output logic               retire_valid,
  output logic [pc_w-1:0]    retire_pc,
  output logic               retire_branch,
  output logic               retire_taken,
  output logic [pc_w-1:0]    retire_target,
  output state_t             retire_prediction,
  output logic               mispredict
);

  logic            is_branch;     // Opcode decode.
  logic [pc_w-1:0] seq_pc;        // id_pc + 2.
  logic [pc_w-1:0] offset_bytes;  // Sign extended word offset times two.
  logic            dir_wrong;     // Direction mispredicted.
  logic            tgt_wrong;     // Right direction, wrong place.

  ////////////////////
  // Decode
  ////////////////////
  assign is_branch    = (id_instr.generic.opcode == branch_op);
  assign seq_pc       = id_pc + pc_w'(2);
  assign offset_bytes = {{(pc_w-10){id_instr.branch.offset[8]}}, id_instr.branch.offset, 1'b0};

  assign actual_taken  = is_branch && |(id_instr.branch.cond & flags);  // Any masked flag.
  assign actual_target = seq_pc + offset_bytes;

  ////////////////////
  // Prediction check
  ////////////////////
  assign dir_wrong = (id_predicted_taken != actual_taken);
  assign tgt_wrong = actual_taken && id_predicted_taken
                     && (id_predicted_target != actual_target);

  assign redirect    = id_valid && is_branch && (dir_wrong || tgt_wrong);
  assign redirect_pc = actual_taken ? actual_target : seq_pc;

  // Predictor updates, applied at the end of this cycle.
  assign wen_bht = id_valid && is_branch;
  assign wen_btb = id_valid && actual_taken;

  ////////////////////
  // Retire report
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
      mispredict   <= 1'b0;
    end else begin
      retire_valid <= id_valid;
      mispredict   <= redirect;  // Same cycle as its retire.
    end
  end

  always_ff @(posedge clk) begin
    retire_pc         <= id_pc;
    retire_branch     <= is_branch;
    retire_taken      <= actual_taken;
    retire_target     <= is_branch ? actual_target : seq_pc;  // Fall-through if no branch.
    retire_prediction <= id_prediction;
  end

  // A redirect comes from a live slot and empties the next one.
  a_redirect_flush : assert property (
    @(posedge clk) disable iff (rst) redirect |-> id_valid ##1 !id_valid
  );

endmodule

//--- logic/branch_unit_top.sv
/*
 * Top level of the fetch/decode front end. Wires fetch, predictor
 * and decode together and passes the table size down.
 */
`timescale 1ns/10ps

module branch_unit_top
  import bp_pkg::*;
#(
  parameter int index_bits = 3  // 8 BHT/BTB entries.
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               enable,         // Predictor on.
  input  instr_t             instr,          // Word at fetch_pc.
  input  logic [flag_w-1:0]  flags,
  output logic [pc_w-1:0]    fetch_pc,
  output logic               retire_valid,
  output logic [pc_w-1:0]    retire_pc,
  output logic               retire_branch,
  output logic               retire_taken,
  output logic [pc_w-1:0]    retire_target,
  output state_t             retire_prediction,
  output logic               mispredict
);

  // Predictor to fetch.
  logic            predicted_taken;
  state_t          prediction;
  logic [pc_w-1:0] predicted_target;

  // Fetch to decode.
  logic            id_valid;
  logic [pc_w-1:0] id_pc;
  instr_t          id_instr;
  state_t          id_prediction;
  logic            id_predicted_taken;
  logic [pc_w-1:0] id_predicted_target;

  // Decode to predictor and fetch.
  logic            wen_bht;
  logic            wen_btb;
  logic            actual_taken;
  logic [pc_w-1:0] actual_target;
  logic            redirect;
  logic [pc_w-1:0] redirect_pc;

  fetch_stage fetch_i (
    .clk, .rst, .instr,
    .predicted_taken, .prediction, .predicted_target,
    .redirect, .redirect_pc,
    .fetch_pc, .id_valid, .id_pc, .id_instr,
    .id_prediction, .id_predicted_taken, .id_predicted_target
  );

  branch_predictor #(.index_bits(index_bits)) predictor_i (
    .clk, .rst, .enable, .fetch_pc, .id_pc, .id_prediction,
    .wen_bht, .wen_btb, .actual_taken, .actual_target,
    .predicted_taken, .prediction, .predicted_target
  );

  branch_resolver resolver_i (
    .clk, .rst, .id_valid, .id_pc, .id_instr, .id_prediction,
    .id_predicted_taken, .id_predicted_target, .flags,
    .wen_bht, .wen_btb, .actual_taken, .actual_target,
    .redirect, .redirect_pc,
    .retire_valid, .retire_pc, .retire_branch, .retire_taken,
    .retire_target, .retire_prediction, .mispredict
  );

endmodule

//--- testbench/tb_ref_model.svh
/*
 * Reference model for the front end testbench. Holds the LFSR, a shadow
 * copy of the BHT/BTB and the functions that give the expected result of
 * each decoded instruction. Included inside the testbench module.
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int tag_w = 16 - idx_bits;  // Upper PC bits plus bit 0.
localparam int depth = 1 << idx_bits;

logic [31:0]      rnd;                 // LFSR state.
logic             sh_valid [depth];    // Shadow BHT.
logic [1:0]       sh_state [depth];
logic [tag_w-1:0] sh_tag [depth];
logic [tag_w-1:0] sh_btb_tag [depth];  // Shadow BTB.
logic [15:0]      sh_btb_target [depth];

////////////////////
// Random source
////////////////////
// Fibonacci LFSR, taps 32 22 2 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic draw(input int n, output logic [15:0] v);
  v = '0;
  for (int i = 0; i < n; i++) begin
    rnd = lfsr_next(rnd);  // One step per bit.
    v = {v[14:0], rnd[0]};
  end
endtask

////////////////////
// Tables
////////////////////
task automatic model_tables_reset();
  for (int i = 0; i < depth; i++) begin
    sh_valid[i]      = 1'b0;  // Every entry misses.
    sh_state[i]      = 2'd0;
    sh_tag[i]        = '0;
    sh_btb_tag[i]    = '0;
    sh_btb_target[i] = '0;
  end
endtask

function automatic logic [tag_w-1:0] tag_of(input logic [15:0] pc);
  return {pc[15:idx_bits+1], pc[0]};
endfunction

function automatic int index_of(input logic [15:0] pc);
  return int'(pc[idx_bits:1]);  // Bit 0 skipped.
endfunction

// Prediction seen by fetch for pc.
task automatic predict(input logic [15:0] pc, input logic en,
                       output logic [1:0] st, output logic tk, output logic [15:0] tgt);
  int i;
  i = index_of(pc);
  st = (en && sh_valid[i] && sh_tag[i] == tag_of(pc)) ? sh_state[i] : 2'd1;
  tk = st[1];  // Taken states.
  tgt = (en && sh_btb_tag[i] == tag_of(pc)) ? sh_btb_target[i] : 16'h0000;
endtask

// Counter step from the state used at fetch.
task automatic train(input logic [15:0] pc, input logic [1:0] used,
                     input logic taken, input logic [15:0] target);
  int i;
  logic match;
  logic [1:0] nxt;
  i = index_of(pc);
  match = (sh_tag[i] == tag_of(pc));
  case (used)
    2'd0:    nxt = !match ? 2'd1 : (taken ? 2'd1 : 2'd0);
    2'd1:    nxt = taken ? 2'd2 : 2'd0;
    2'd2:    nxt = !match ? 2'd1 : (taken ? 2'd3 : 2'd1);
    default: nxt = !match ? 2'd1 : (taken ? 2'd3 : 2'd2);  // Saturates.
  endcase
  sh_valid[i] = 1'b1;
  sh_tag[i]   = tag_of(pc);
  sh_state[i] = nxt;
  if (taken) begin
    sh_btb_tag[i]    = tag_of(pc);
    sh_btb_target[i] = target;  // Resolved target.
  end
endtask

// Outcome of one decoded word against the prediction it carries.
function automatic void expect_result(
  input  logic [15:0] pc,
  input  logic [15:0] word,
  input  logic [2:0]  flg,
  input  logic        ptaken,
  input  logic [15:0] ptarget,
  output logic        is_br,
  output logic        taken,
  output logic [15:0] target,
  output logic        misp
);
  logic [15:0] off;
  off    = {{6{word[8]}}, word[8:0], 1'b0};  // Words to bytes.
  is_br  = (word[15:12] == branch_op);
  taken  = is_br && ((word[11:9] & flg) != 3'b000);
  target = is_br ? pc + 16'd2 + off : pc + 16'd2;
  misp   = is_br && ((ptaken != taken) || (taken && ptarget != target));
endfunction

`endif

//--- testbench/tb_branch_unit.sv
/*
 * Testbench for the fetch/decode front end. Runs a random program with
 * branches and loops, models fetch and decode cycle by cycle and checks
 * every retire output, fetch_pc and the redirect behavior.
 */
`timescale 1ns/10ps

module tb_branch_unit
  import bp_pkg::*;
;

  localparam int idx_bits   = 3;    // Table size passed to the DUT.
  localparam int prog_words = 256;  // Program wraps on pc[8:1].
  localparam int run_cycles = 1200;

  logic        clk = 1'b0;
  logic        rst;
  logic        enable;
  logic [15:0] instr;
  logic [2:0]  flags;
  logic [15:0] fetch_pc;
  logic        retire_valid;
  logic [15:0] retire_pc;
  logic        retire_branch;
  logic        retire_taken;
  logic [15:0] retire_target;
  logic [1:0]  retire_prediction;
  logic        mispredict;

  logic [15:0] prog [prog_words];

  // Model of fetch and the decode slot.
  logic [15:0] model_pc;
  logic        slot_valid;
  logic [15:0] slot_pc;
  logic [15:0] slot_instr;
  logic [1:0]  slot_state;
  logic        slot_ptaken;
  logic [15:0] slot_ptarget;

  // Expected retire report after the next rising edge.
  logic        exp_valid;
  logic [15:0] exp_pc;
  logic        exp_branch;
  logic        exp_taken;
  logic [15:0] exp_target;
  logic [1:0]  exp_pred;
  logic        exp_misp;

  logic        flush_next;     // Slot after a mispredict is empty.
  logic        redirect_due;
  logic [15:0] redirect_want;
  int          mismatch_count;
  int          failure_count;

  `include "tb_ref_model.svh"

  always #50 clk = ~clk;  // 100 ns period.

  branch_unit_top #(.index_bits(idx_bits)) dut_i (
    .clk, .rst, .enable, .instr, .flags,
    .fetch_pc, .retire_valid, .retire_pc, .retire_branch, .retire_taken,
    .retire_target, .retire_prediction, .mispredict
  );

  task automatic mismatch(input string name, input logic [15:0] got, input logic [15:0] want);
    mismatch_count++;
    $display("MISMATCH %s got %h expected %h at %0t", name, got, want, $time);
  endtask

  task automatic fault(input string msg);
    failure_count++;
    $display("ERROR %s at %0t", msg, $time);
  endtask

  ////////////////////
  // Program
  ////////////////////
  task automatic build_program();
    logic [15:0] kind;
    logic [15:0] op;
    logic [15:0] bits;
    logic [15:0] cond;
    logic [8:0]  off;
    for (int a = 0; a < prog_words; a++) begin
      draw(2, kind);
      if (kind[1:0] == 2'd0) begin
        draw(4, op);                                   // Plain word.
        if (op[3:0] == branch_op) begin
          op = 16'h0;
        end
        draw(12, bits);
        prog[a] = {op[3:0], bits[11:0]};
      end else if (kind[1:0] == 2'd3) begin
        draw(1, bits);                                 // Backward loop.
        draw(3, cond);
        if (bits[0]) begin
          cond = 16'h7;                                // Almost always taken.
        end
        draw(2, bits);
        off = 9'd0 - 9'(bits[1:0]) - 9'd2;
        prog[a] = {branch_op, cond[2:0], off};
      end else begin
        draw(3, cond);                                 // Short hop.
        draw(4, bits);
        off = {{5{bits[3]}}, bits[3:0]};
        prog[a] = {branch_op, cond[2:0], off};
      end
    end
  endtask

  ////////////////////
  // Model step
  ////////////////////
  task automatic model_cycle();
    logic        is_br;
    logic        taken;
    logic        misp;
    logic        redir;
    logic        ptk;
    logic [1:0]  pst;
    logic [15:0] tgt;
    logic [15:0] ptgt;
    logic [15:0] rpc;
    expect_result(slot_pc, slot_instr, flags, slot_ptaken, slot_ptarget,
                  is_br, taken, tgt, misp);
    redir      = slot_valid && misp;
    rpc        = taken ? tgt : slot_pc + 16'd2;
    exp_valid  = slot_valid;
    exp_pc     = slot_pc;
    exp_branch = is_br;
    exp_taken  = taken;
    exp_target = tgt;
    exp_pred   = slot_state;
    exp_misp   = redir;
    predict(model_pc, enable, pst, ptk, ptgt);         // Reads old tables.
    if (slot_valid && is_br && enable) begin
      train(slot_pc, slot_state, taken, tgt);          // Written at the edge.
    end
    slot_valid   = !redir;                             // Wrong path dropped.
    slot_pc      = model_pc;
    slot_instr   = prog[model_pc[8:1]];
    slot_state   = pst;
    slot_ptaken  = ptk;
    slot_ptarget = ptgt;
    model_pc     = redir ? rpc : (ptk ? ptgt : model_pc + 16'd2);
  endtask

  // Inputs for one cycle, driven on the falling edge.
  task automatic drive_cycle(input int c);
    logic [15:0] f;
    enable = !(c >= 500 && c < 600);                   // Predictor off stretch.
    draw(3, f);
    flags = f[2:0];
    instr = prog[fetch_pc[8:1]];
    model_cycle();
  endtask

  ////////////////////
  // Comparison
  ////////////////////
  always @(posedge clk) begin
    #5;
    if (!rst) begin
      assert (fetch_pc === model_pc) else mismatch("fetch_pc", fetch_pc, model_pc);
      assert (retire_valid === exp_valid) else mismatch("retire_valid", retire_valid, exp_valid);
      assert (mispredict === exp_misp) else mismatch("mispredict", mispredict, exp_misp);
      if (exp_valid) begin
        assert (retire_pc === exp_pc) else mismatch("retire_pc", retire_pc, exp_pc);
        assert (retire_branch === exp_branch)
          else mismatch("retire_branch", retire_branch, exp_branch);
        assert (retire_taken === exp_taken)
          else mismatch("retire_taken", retire_taken, exp_taken);
        assert (retire_target === exp_target)
          else mismatch("retire_target", retire_target, exp_target);
        assert (retire_prediction === exp_pred)
          else mismatch("retire_prediction", retire_prediction, exp_pred);
      end
      if (flush_next) begin
        assert (retire_valid === 1'b0) else fault("wrong-path instruction retired");
        flush_next = 1'b0;
      end
      if (exp_valid) begin
        if (redirect_due) begin
          assert (retire_pc === redirect_want)
            else mismatch("retire_pc", retire_pc, redirect_want);  // Redirect target.
          redirect_due = 1'b0;
        end
        if (exp_misp) begin
          flush_next    = 1'b1;
          redirect_due  = 1'b1;
          redirect_want = exp_taken ? exp_target : exp_pc + 16'd2;
        end
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin
    int waited;
    rst    = 1'b1;
    enable = 1'b1;
    instr  = '0;
    flags  = '0;
    rnd    = 32'h784eb463;
    mismatch_count = 0;
    failure_count  = 0;
    flush_next     = 1'b0;
    redirect_due   = 1'b0;
    redirect_want  = '0;
    build_program();
    model_tables_reset();
    model_pc   = '0;
    slot_valid = 1'b0;
    slot_pc    = '0;
    slot_instr = '0;
    slot_state = 2'd0;
    slot_ptaken  = 1'b0;
    slot_ptarget = '0;
    exp_valid  = 1'b0;
    exp_misp   = 1'b0;
    repeat (8) @(negedge clk);                         // Eight reset cycles.
    rst = 1'b0;
    drive_cycle(0);
    for (int c = 1; c < run_cycles; c++) begin
      @(negedge clk);
      drive_cycle(c);
    end
    waited = 0;
    while (retire_valid !== 1'b1 && waited < 20) begin
      @(negedge clk);
      drive_cycle(run_cycles);
      waited++;
    end
    if (waited >= 20) begin
      fault("timeout waiting for a retired instruction");
    end
    @(negedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+testbench
logic/bp_pkg.sv
logic/fetch_stage.sv
logic/branch_predictor.sv
logic/branch_resolver.sv
logic/branch_unit_top.sv
testbench/tb_branch_unit.sv

//--- Makefile
TOP := tb_branch_unit

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
